/* include/fft_ctrl_macros.svh */
`ifndef FFT_CTRL_MACROS_SVH
`define FFT_CTRL_MACROS_SVH

// Points per FFT frame
`define FFT_POINTS 64

// Radix-2 butterfly stages, log2 of the point count
`define FFT_STAGES 6

// The schedule spans fill plus drain, which is two frames of positions
`define COUNT_W 7

// Twiddle index width of the last stage, the widest one
`define TW_W 5

`endif

/* rtl/fft_ctrl_pkg.sv */
`include "fft_ctrl_macros.svh"

package fft_ctrl_pkg;

        // Position inside the frame schedule
        typedef logic [`COUNT_W-1:0] count_t;

        // Twiddle ROM index of which stage k uses the low k-1 bits
        typedef logic [`TW_W-1:0] tw_idx_t;

        // Phase of one SDF stage as seen from the frame count
        typedef enum logic [2:0] {
                PH_IDLE,  // Stage has no samples of this frame
                PH_FILL,  // First D samples are written into the feedback buffer
                PH_PASS,  // Buffered results leave the stage
                PH_BFLY,  // Butterfly between buffer and incoming sample
                PH_FLUSH  // Last results drain out of the buffer
        } stage_phase_e;

endpackage

/* rtl/frame_sequencer.sv */
`timescale 1ns/10ps
`include "fft_ctrl_macros.svh"

module frame_sequencer
        import fft_ctrl_pkg::*;
(
        input  logic   clk,
        input  logic   rst_n,
        input  logic   enable,
        output count_t count,
        output logic   done_tick
);

        // Highest position of the schedule, 127 for a 64-point frame
        localparam count_t LAST_COUNT = count_t'(2 * `FFT_POINTS - 1);

        // Free running schedule counter that only moves while enabled
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        count <= '0;
                end else if (enable) begin
                        count <= count + 1'b1; // Rolls over from LAST_COUNT to 0
                end
        end

        // Flag the last two positions so the consumer sees the frame end coming
        always_comb begin
                done_tick = 1'b0;
                if (count >= LAST_COUNT - 1'b1) begin
                        done_tick = 1'b1;
                end
        end

        // Outputs are frozen while the pipeline is stalled
        hold_when_disabled: assert property (
                @(posedge clk) disable iff (!rst_n)
                !enable |=> $stable(count)
        );

        wrap_after_done: assert property (
                @(posedge clk) disable iff (!rst_n)
                (done_tick && enable && count == LAST_COUNT) |=> (count == '0 && !done_tick)
        ) else $error("frame_sequencer: schedule did not restart after done_tick");

endmodule

/* rtl/sdf_stage_ctrl.sv */
`timescale 1ns/10ps
`include "fft_ctrl_macros.svh"

module sdf_stage_ctrl
        import fft_ctrl_pkg::*;
#(
        parameter int STAGE = 1
) (
        input  count_t  count,
        output logic    buf_out_sel,
        output logic    buf_in_sel,
        output tw_idx_t tw_sel
);

        // Feedback delay halves with every stage, 32 for stage 1 and 1 for stage 6
        localparam int DELAY  = `FFT_POINTS >> STAGE;
        localparam int D_LOG  = $clog2(DELAY);

        // Stage k sees its first sample 2D positions before the frame midpoint
        localparam int START  = `FFT_POINTS - 2 * DELAY;

        // Largest twiddle index, all ones in k-1 bits
        localparam int TW_MAX = (`FFT_POINTS / 2) / DELAY - 1;

        stage_phase_e phase;
        count_t       rel;      // Position relative to the stage start
        count_t       tw_pos;
        count_t       tw_raw;

        if (STAGE < 1 || STAGE > `FFT_STAGES) begin : g_bad_stage
                $error("sdf_stage_ctrl: STAGE %0d outside 1..%0d", STAGE, `FFT_STAGES);
        end

        assign rel = count - count_t'(START);

        always_comb begin
                if (count < count_t'(START)) begin
                        phase = PH_IDLE;
                end else if (rel < count_t'(DELAY)) begin
                        phase = PH_FILL;
                end else if (rel < count_t'(`FFT_POINTS)) begin
                        // Blocks of D alternate between pass and butterfly
                        phase = rel[D_LOG] ? PH_PASS : PH_BFLY;
                end else if (rel < count_t'(`FFT_POINTS + DELAY)) begin
                        phase = PH_FLUSH;
                end else begin
                        phase = PH_IDLE;
                end
        end

        // Unused selects are tied low rather than left open
        always_comb begin
                buf_out_sel = 1'b0;
                buf_in_sel  = 1'b0;
                case (phase)
                        PH_FILL,
                        PH_BFLY: begin
                                buf_in_sel = 1'b1;
                        end
                        PH_PASS: begin
                                buf_out_sel = 1'b1;
                        end
                        default: begin
                                buf_out_sel = 1'b0;
                                buf_in_sel  = 1'b0;
                        end
                endcase
        end

        // The twiddle index steps once every 2D positions after the midpoint,
        // offset by D so that it changes on the butterfly boundary
        assign tw_pos = count - count_t'(`FFT_POINTS - DELAY);
        assign tw_raw = tw_pos >> (D_LOG + 1);

        always_comb begin
                if (count < count_t'(`FFT_POINTS)) begin
                        tw_sel = '0;
                end else if (tw_raw > count_t'(TW_MAX)) begin
                        tw_sel = tw_idx_t'(TW_MAX); // Holds the last index through the tail
                end else begin
                        tw_sel = tw_idx_t'(tw_raw);
                end
        end

        // Buffer input and output multiplexers never drive the same cycle
        always_comb begin
                sel_exclusive: assert final (!(buf_in_sel && buf_out_sel))
                        else $error("sdf_stage_ctrl %0d: both selects high at count %0d",
                                    STAGE, count);
        end

        always_comb begin
                tw_in_range: assert final (tw_sel <= tw_idx_t'(TW_MAX))
                        else $error("sdf_stage_ctrl %0d: tw_sel %0h above %0h",
                                    STAGE, tw_sel, TW_MAX);
        end

endmodule

/* rtl/fft_control_unit.sv */
`timescale 1ns/10ps
`include "fft_ctrl_macros.svh"

module fft_control_unit
        import fft_ctrl_pkg::*;
(
        input  logic       clk,
        input  logic       rst_n,
        input  logic       enable,

        output logic       buffer_out_sel_s1,
        output logic       buffer_in_sel_s1,
        output logic       buffer_out_sel_s2,
        output logic       buffer_in_sel_s2,
        output logic       buffer_out_sel_s3,
        output logic       buffer_in_sel_s3,
        output logic       buffer_out_sel_s4,
        output logic       buffer_in_sel_s4,
        output logic       buffer_out_sel_s5,
        output logic       buffer_in_sel_s5,
        output logic       buffer_out_sel_s6,
        output logic       buffer_in_sel_s6,

        output logic       tw_sel_s2,
        output logic [1:0] tw_sel_s3,
        output logic [2:0] tw_sel_s4,
        output logic [3:0] tw_sel_s5,
        output logic [4:0] tw_sel_s6,

        output logic       done_tick
);

        count_t                 frame_count;
        logic [`FFT_STAGES:1]   out_sel_w;
        logic [`FFT_STAGES:1]   in_sel_w;
        tw_idx_t                tw_w [1:`FFT_STAGES];

        frame_sequencer frame_sequencer_i (
                .clk       (clk),
                .rst_n     (rst_n),
                .enable    (enable),
                .count     (frame_count),
                .done_tick (done_tick)
        );

        // One decoder per butterfly stage, all driven from the shared count
        for (genvar s = 1; s <= `FFT_STAGES; s++) begin : g_stage
                sdf_stage_ctrl #(
                        .STAGE (s)
                ) stage_ctrl_i (
                        .count       (frame_count),
                        .buf_out_sel (out_sel_w[s]),
                        .buf_in_sel  (in_sel_w[s]),
                        .tw_sel      (tw_w[s])
                );

                // Slicing to k-1 bits at the ports is only lossless if the upper bits stay zero
                tw_fits_port: assert property (
                        @(posedge clk) disable iff (!rst_n)
                        (tw_w[s] >> (s - 1)) == '0
                );
        end

        assign buffer_out_sel_s1 = out_sel_w[1];
        assign buffer_in_sel_s1  = in_sel_w[1];
        assign buffer_out_sel_s2 = out_sel_w[2];
        assign buffer_in_sel_s2  = in_sel_w[2];
        assign buffer_out_sel_s3 = out_sel_w[3];
        assign buffer_in_sel_s3  = in_sel_w[3];
        assign buffer_out_sel_s4 = out_sel_w[4];
        assign buffer_in_sel_s4  = in_sel_w[4];
        assign buffer_out_sel_s5 = out_sel_w[5];
        assign buffer_in_sel_s5  = in_sel_w[5];
        assign buffer_out_sel_s6 = out_sel_w[6];
        assign buffer_in_sel_s6  = in_sel_w[6];

        // Stage 1 multiplies by W^0 only so its index has no port
        assign tw_sel_s2 = tw_w[2][0];
        assign tw_sel_s3 = tw_w[3][1:0];
        assign tw_sel_s4 = tw_w[4][2:0];
        assign tw_sel_s5 = tw_w[5][3:0];
        assign tw_sel_s6 = tw_w[6][4:0];

        // By the time done_tick rises every stage has drained its buffer
        quiet_at_done: assert property (
                @(posedge clk) disable iff (!rst_n)
                done_tick |-> (out_sel_w == '0 && in_sel_w == '0)
        ) else $error("fft_control_unit: buffer select active during done_tick");

        // A new frame opens with stage 1 filling and every twiddle at W^0
        frame_start: assert property (
                @(posedge clk) disable iff (!rst_n)
                frame_count == '0 |-> (in_sel_w == `FFT_STAGES'(1) && out_sel_w == '0 &&
                                       tw_w[`FFT_STAGES] == '0)
        );

endmodule

/* sim/fft_ctrl_model.sv */
`include "fft_ctrl_macros.svh"

package fft_ctrl_model;

        import fft_ctrl_pkg::*;

        // Schedule position that the DUT is expected to hold
        count_t model_count;

        function automatic void reset_model();
                model_count = '0;
        endfunction

        function automatic void advance_model(input logic en);
                if (en) begin
                        model_count = count_t'((int'(model_count) + 1) % (2 * `FFT_POINTS));
                end
        endfunction

        // Feedback delay of stage k, halving from 32 down to 1
        function automatic int stage_delay(input int stage);
                return `FFT_POINTS / (1 << stage);
        endfunction

        function automatic stage_phase_e exp_phase(input int stage, input int count);
                int d;
                int r;
                d = stage_delay(stage);
                r = count - (`FFT_POINTS - 2 * d);
                if (r < 0) return PH_IDLE;
                if (r < d) return PH_FILL;
                if (r < `FFT_POINTS) return ((r / d) % 2 == 1) ? PH_PASS : PH_BFLY;
                if (r < `FFT_POINTS + d) return PH_FLUSH;
                return PH_IDLE;
        endfunction

        function automatic logic exp_in_sel(input int stage, input int count);
                stage_phase_e ph;
                ph = exp_phase(stage, count);
                return (ph == PH_FILL || ph == PH_BFLY);
        endfunction

        function automatic logic exp_out_sel(input int stage, input int count);
                return exp_phase(stage, count) == PH_PASS;
        endfunction

        function automatic int exp_tw_sel(input int stage, input int count);
                int d;
                int idx;
                int top;
                d = stage_delay(stage);
                top = (`FFT_POINTS / 2) / d - 1;  // All ones in k-1 bits
                if (count < `FFT_POINTS) return 0;
                idx = (count - `FFT_POINTS + d) / (2 * d);
                return (idx > top) ? top : idx;
        endfunction

        // Last two positions of the two-frame schedule
        function automatic logic exp_done(input int count);
                return count >= 2 * `FFT_POINTS - 2;
        endfunction

endpackage

/* sim/tb_fft_control_unit.sv */
`timescale 1ns/10ps
`include "fft_ctrl_macros.svh"

module tb_fft_control_unit
        import fft_ctrl_pkg::*;
        import fft_ctrl_model::*;
();

        localparam int CLK_PERIOD      = 100;
        localparam int RESET_CYCLES    = 4;
        localparam logic [31:0] SEED   = 32'h2002_2a6f;
        localparam int FRAME_LEN       = 2 * `FFT_POINTS;
        localparam int MID_RESET_STEP  = 2 * FRAME_LEN + 45; // Middle of the third frame
        localparam int RUN_STEPS       = MID_RESET_STEP + 2 * FRAME_LEN + 8;
        // Enable is high about three cycles in four
        localparam int EXPECTED_CYCLES = RUN_STEPS * 4 / 3 + 2 * (RESET_CYCLES + 1) + 4;
        localparam int TIMEOUT_CYCLES  = 2 * EXPECTED_CYCLES;

        // Only in_sel of stage 1 is high right after reset, which is bit 16 of the bundle
        localparam logic [27:0] RESET_OUTPUTS = 28'h001_0000;

        logic clk;
        logic rst_n;
        logic enable;

        logic buffer_out_sel_s1, buffer_out_sel_s2, buffer_out_sel_s3;
        logic buffer_out_sel_s4, buffer_out_sel_s5, buffer_out_sel_s6;
        logic buffer_in_sel_s1, buffer_in_sel_s2, buffer_in_sel_s3;
        logic buffer_in_sel_s4, buffer_in_sel_s5, buffer_in_sel_s6;
        logic       tw_sel_s2;
        logic [1:0] tw_sel_s3;
        logic [2:0] tw_sel_s4;
        logic [3:0] tw_sel_s5;
        logic [4:0] tw_sel_s6;
        logic       done_tick;

        logic [6:1]  out_sel_obs;
        logic [6:1]  in_sel_obs;
        logic [4:0]  tw_obs [2:6];
        logic [27:0] outputs_now;
        logic [27:0] outputs_prev;

        logic checks_on     = 1'b0;
        logic hold_expected = 1'b0;
        int   enabled_steps = 0;
        int   cycle_count   = 0;

        fft_control_unit dut_i (
                .clk               (clk),
                .rst_n             (rst_n),
                .enable            (enable),
                .buffer_out_sel_s1 (buffer_out_sel_s1),
                .buffer_in_sel_s1  (buffer_in_sel_s1),
                .buffer_out_sel_s2 (buffer_out_sel_s2),
                .buffer_in_sel_s2  (buffer_in_sel_s2),
                .buffer_out_sel_s3 (buffer_out_sel_s3),
                .buffer_in_sel_s3  (buffer_in_sel_s3),
                .buffer_out_sel_s4 (buffer_out_sel_s4),
                .buffer_in_sel_s4  (buffer_in_sel_s4),
                .buffer_out_sel_s5 (buffer_out_sel_s5),
                .buffer_in_sel_s5  (buffer_in_sel_s5),
                .buffer_out_sel_s6 (buffer_out_sel_s6),
                .buffer_in_sel_s6  (buffer_in_sel_s6),
                .tw_sel_s2         (tw_sel_s2),
                .tw_sel_s3         (tw_sel_s3),
                .tw_sel_s4         (tw_sel_s4),
                .tw_sel_s5         (tw_sel_s5),
                .tw_sel_s6         (tw_sel_s6),
                .done_tick         (done_tick)
        );

        assign out_sel_obs = {buffer_out_sel_s6, buffer_out_sel_s5, buffer_out_sel_s4,
                              buffer_out_sel_s3, buffer_out_sel_s2, buffer_out_sel_s1};
        assign in_sel_obs  = {buffer_in_sel_s6, buffer_in_sel_s5, buffer_in_sel_s4,
                              buffer_in_sel_s3, buffer_in_sel_s2, buffer_in_sel_s1};
        assign tw_obs[2] = 5'(tw_sel_s2);
        assign tw_obs[3] = 5'(tw_sel_s3);
        assign tw_obs[4] = 5'(tw_sel_s4);
        assign tw_obs[5] = 5'(tw_sel_s5);
        assign tw_obs[6] = tw_sel_s6;
        assign outputs_now = {out_sel_obs, in_sel_obs, tw_sel_s6, tw_sel_s5, tw_sel_s4,
                              tw_sel_s3, tw_sel_s2, done_tick};

        initial begin
                clk = 1'b0;
                forever #(CLK_PERIOD / 2) clk = ~clk;
        end

        task automatic fail_run();
                $display("sim failed");
                $fatal(1, "run stopped at the first error");
        endtask

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
                value_check: assert (got === expected) else begin
                        $display("MISMATCH %s: got 0x%0h expected 0x%0h at count 0x%0h",
                                 name, got, expected, model_count);
                        fail_run();
                end
        endtask

        task automatic compare_with_model();
                int c;
                c = int'(model_count);
                for (int k = 1; k <= `FFT_STAGES; k++) begin
                        check_value($sformatf("buffer_out_sel_s%0d", k),
                                    32'(out_sel_obs[k]), 32'(exp_out_sel(k, c)));
                        check_value($sformatf("buffer_in_sel_s%0d", k),
                                    32'(in_sel_obs[k]), 32'(exp_in_sel(k, c)));
                        if (k >= 2) begin
                                check_value($sformatf("tw_sel_s%0d", k),
                                            32'(tw_obs[k]), 32'(exp_tw_sel(k, c)));
                        end
                end
                check_value("done_tick", 32'(done_tick), 32'(exp_done(c)));
        endtask

        // One clock edge: update the model from what the DUT sampled, then drive new inputs
        task automatic step_cycle(input logic next_rst_n, input logic next_enable);
                @(posedge clk);
                hold_expected = rst_n && !enable && next_rst_n;
                if (!rst_n) begin
                        reset_model();
                end else begin
                        if (enable) begin
                                enabled_steps++;
                        end
                        advance_model(enable);
                end
                if (!next_rst_n) begin
                        reset_model();  // Asynchronous reset clears the count within this cycle
                end
                checks_on = 1'b1;
                rst_n  <= next_rst_n;
                enable <= next_enable;
        endtask

        task automatic apply_reset();
                repeat (RESET_CYCLES) step_cycle(1'b0, 1'b0);
                step_cycle(1'b1, 1'b0);
        endtask

        task automatic run_until_steps(input int target);
                while (enabled_steps < target) begin
                        step_cycle(1'b1, ($urandom % 4) != 0);
                end
        endtask

        // Outputs are combinational from the count, so they are settled by the falling edge
        always @(negedge clk) begin
                if (checks_on) begin
                        if (!rst_n) begin
                                check_value("all outputs in reset", 32'(outputs_now),
                                            32'(RESET_OUTPUTS));
                        end
                        if (hold_expected) begin
                                check_value("all outputs with enable low", 32'(outputs_now),
                                            32'(outputs_prev));
                        end
                        compare_with_model();
                end
                outputs_prev = outputs_now;
        end

        always @(posedge clk) begin
                cycle_count++;
                run_time_limit: assert (cycle_count < TIMEOUT_CYCLES) else begin
                        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
                        fail_run();
                end
        end

        initial begin
                void'($urandom(SEED));
                rst_n  <= 1'b0;
                enable <= 1'b0;
                reset_model();
                apply_reset();
                run_until_steps(MID_RESET_STEP);
                apply_reset();
                run_until_steps(RUN_STEPS);
                @(posedge clk);

                $display("sim passed");
                $finish;
        end

endmodule

/* fft_control_unit.f */
+incdir+include
rtl/fft_ctrl_pkg.sv
rtl/frame_sequencer.sv
rtl/sdf_stage_ctrl.sv
rtl/fft_control_unit.sv
sim/fft_ctrl_model.sv
sim/tb_fft_control_unit.sv

/* Makefile */
# Verilator build and run for the FFT control unit testbench
# Any variable can be overridden on the command line, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_fft_control_unit
FILELIST  ?= fft_control_unit.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard rtl/*.sv sim/*.sv include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)

# The exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
